//--- verilog/user_pkg.sv
// Shared bus types, register offsets and address map of the user domain.
// Imported by every module of the subsystem.
`default_nettype none

package user_pkg;

  // ------------------------------
  // Address map
  // ------------------------------

  // Region field is addr[15:12]
  localparam int unsigned RegionLsb = 12;
  // Region of the interrupt controller, timers follow from region 1
  localparam int unsigned RegionIrq = 0;
  // Upper bound for the number of timers
  localparam int unsigned MaxTimers = 15;
  // Error, irq and all timers
  localparam int unsigned NumTargetsMax = MaxTimers + 2;
  localparam int unsigned TgtIdxW = $clog2(NumTargetsMax);

  // Pattern returned by the error subordinate
  localparam logic [31:0] ErrRspData = 32'hBADCAB1E;

  // ------------------------------
  // Bus structs
  // ------------------------------

  typedef struct packed {
    logic        req;
    logic        we;
    logic [3:0]  be;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [3:0]  aid;
  } obi_req_t;

  typedef struct packed {
    logic        gnt;
    logic        rvalid;
    logic        err;
    logic [31:0] rdata;
    logic [3:0]  rid;
  } obi_rsp_t;

  // ------------------------------
  // Decode targets and registers
  // ------------------------------

  // Demux port order, timers start at TargetTimer
  typedef enum logic [TgtIdxW-1:0] {
    TargetErr   = TgtIdxW'(0),
    TargetIrq   = TgtIdxW'(1),
    TargetTimer = TgtIdxW'(2)
  } target_e;

  // Timer word offsets, addr[3:2]
  typedef enum logic [1:0] {
    TimerCtrl    = 2'd0,
    TimerCount   = 2'd1,
    TimerCompare = 2'd2
  } timer_reg_e;

  // Irq controller word offsets, addr[3:2]
  typedef enum logic [1:0] {
    IrqPending = 2'd0,
    IrqMask    = 2'd1
  } irq_reg_e;

  // Expand byte enables into a bit mask
  function automatic logic [31:0] be_to_mask(input logic [3:0] be);
    logic [31:0] mask;
    for (int i = 0; i < 4; i++) begin
      mask[8*i +: 8] = {8{be[i]}};
    end
    return mask;
  endfunction

  // Write only the enabled bytes of a register
  function automatic logic [31:0] merge_be(input logic [31:0] old_val,
                                           input logic [31:0] wdata,
                                           input logic [3:0]  be);
    logic [31:0] mask;
    mask = be_to_mask(be);
    return (old_val & ~mask) | (wdata & mask);
  endfunction

endpackage

`default_nettype wire

//--- verilog/user_obi_demux.sv
// Routes OBI requests to one subordinate by address region.
// Responses come back in order, one cycle after their grant.
`timescale 1ns/1ns
`default_nettype none

module user_obi_demux #(
  parameter int unsigned NumTimers = 4
) (
  input  logic                                clk_i,
  input  logic                                rst_n_i,
  input  user_pkg::obi_req_t                  sbr_req_i,
  output user_pkg::obi_rsp_t                  sbr_rsp_o,
  output user_pkg::obi_req_t [NumTimers+1:0]  mgr_req_o,
  input  user_pkg::obi_rsp_t [NumTimers+1:0]  mgr_rsp_i
);
  import user_pkg::*;

  localparam int unsigned NumTgt = NumTimers + 2;

  // Decoded region and selected target
  logic [3:0]         region;
  logic [TgtIdxW-1:0] sel_idx;
  logic               sel_gnt;

  // Target of the request in its response cycle
  logic [TgtIdxW-1:0] rsp_idx_q;
  logic               rsp_pend_q;
  obi_rsp_t           rsp_sel;

  // ------------------------------
  // Address decode
  // ------------------------------

  assign region = sbr_req_i.addr[RegionLsb +: 4];

  always_comb begin
    // Anything outside the map goes to the error subordinate
    sel_idx = TargetErr;
    if (region == 4'(RegionIrq)) begin
      sel_idx = TargetIrq;
    end else if (region != 4'd0 && 32'(region) <= NumTimers) begin
      // Region r maps to timer r-1
      sel_idx = TgtIdxW'(TargetTimer) + TgtIdxW'(region) - TgtIdxW'(1);
    end
  end

  // ------------------------------
  // Request fan-out
  // ------------------------------

  always_comb begin
    sel_gnt = 1'b0;
    for (int i = 0; i < NumTgt; i++) begin
      mgr_req_o[i] = sbr_req_i;
      // Only the decoded target sees req
      mgr_req_o[i].req = sbr_req_i.req && (sel_idx == TgtIdxW'(i));
      if (sel_idx == TgtIdxW'(i)) begin
        sel_gnt = mgr_rsp_i[i].gnt;
      end
    end
  end

  // ------------------------------
  // Response return
  // ------------------------------

  // Remember where the granted request went
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rsp_idx_q  <= '0;
      rsp_pend_q <= 1'b0;
    end else begin
      rsp_pend_q <= sbr_req_i.req & sel_gnt;
      if (sbr_req_i.req && sel_gnt) begin
        rsp_idx_q <= sel_idx;
      end
    end
  end

  // Response mux driven by the recorded index
  always_comb begin
    rsp_sel = '0;
    for (int i = 0; i < NumTgt; i++) begin
      if (rsp_idx_q == TgtIdxW'(i)) begin
        rsp_sel = mgr_rsp_i[i];
      end
    end
  end

  always_comb begin
    sbr_rsp_o.gnt    = sbr_req_i.req & sel_gnt;
    // Ignore stray rvalid with nothing outstanding
    sbr_rsp_o.rvalid = rsp_pend_q & rsp_sel.rvalid;
    sbr_rsp_o.err    = rsp_sel.err;
    sbr_rsp_o.rdata  = rsp_sel.rdata;
    sbr_rsp_o.rid    = rsp_sel.rid;
  end

endmodule

`default_nettype wire

//--- verilog/user_err_sbr.sv
// Subordinate for unmapped regions, answers every access with an error.
`timescale 1ns/1ns
`default_nettype none

module user_err_sbr (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  user_pkg::obi_req_t req_i,
  output user_pkg::obi_rsp_t rsp_o
);
  import user_pkg::*;

  logic       rvalid_q;
  logic [3:0] rid_q;

  // ------------------------------
  // Response state
  // ------------------------------

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rvalid_q <= 1'b0;
    end else begin
      // Always granted, so every req gets a response
      rvalid_q <= req_i.req;
    end
  end

  // Transaction id of the pending response
  always_ff @(posedge clk_i) begin
    if (req_i.req) begin
      rid_q <= req_i.aid;
    end
  end

  // Grant at once, answer with the fixed pattern
  assign rsp_o = '{
    gnt:    req_i.req,
    rvalid: rvalid_q,
    err:    rvalid_q,
    rdata:  rvalid_q ? ErrRspData : 32'd0,
    rid:    rid_q
  };

endmodule

`default_nettype wire

//--- verilog/user_timer.sv
// Compare timer on the OBI bus, counts clk_i cycles and pulses an event
// on a compare match. Registers: control, count and compare value.
`timescale 1ns/1ns
`default_nettype none

module user_timer (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  user_pkg::obi_req_t req_i,
  output user_pkg::obi_rsp_t rsp_o,
  output logic               event_o
);
  import user_pkg::*;

  // Timer state
  logic        enable_q;
  logic [31:0] count_q;
  logic [31:0] count_d;
  logic [31:0] compare_q;
  logic        match;

  // Register access
  timer_reg_e  reg_sel;
  logic        wr_en;
  logic        wr_ctrl;
  logic        wr_count;
  logic        wr_compare;
  logic [31:0] rdata_d;

  // Response
  logic        rvalid_q;
  logic [3:0]  rid_q;
  logic [31:0] rdata_q;

  // ------------------------------
  // Decode
  // ------------------------------

  assign reg_sel    = timer_reg_e'(req_i.addr[3:2]);
  assign wr_en      = req_i.req & req_i.we;
  assign wr_ctrl    = wr_en & (reg_sel == TimerCtrl);
  assign wr_count   = wr_en & (reg_sel == TimerCount);
  assign wr_compare = wr_en & (reg_sel == TimerCompare);

  // ------------------------------
  // Counter
  // ------------------------------

  // Match only counts while running
  assign match   = enable_q & (count_q == compare_q);
  assign event_o = match;

  always_comb begin
    count_d = count_q;
    // Bus write beats counting
    if (wr_count) begin
      count_d = merge_be(count_q, req_i.wdata, req_i.be);
    end else if (enable_q) begin
      count_d = match ? 32'd0 : count_q + 32'd1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      enable_q  <= 1'b0;
      count_q   <= '0;
      compare_q <= '0;
      rvalid_q  <= 1'b0;
    end else begin
      count_q  <= count_d;
      rvalid_q <= req_i.req;
      // Enable lives in byte 0
      if (wr_ctrl && req_i.be[0]) begin
        enable_q <= req_i.wdata[0];
      end
      if (wr_compare) begin
        compare_q <= merge_be(compare_q, req_i.wdata, req_i.be);
      end
    end
  end

  // ------------------------------
  // Read path
  // ------------------------------

  // Value before the write edge
  always_comb begin
    case (reg_sel)
      TimerCtrl:    rdata_d = {31'd0, enable_q};
      TimerCount:   rdata_d = count_q;
      TimerCompare: rdata_d = compare_q;
      default:      rdata_d = 32'd0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (req_i.req) begin
      rid_q   <= req_i.aid;
      rdata_q <= rdata_d;
    end
  end

  assign rsp_o = '{
    gnt:    req_i.req,
    rvalid: rvalid_q,
    err:    1'b0,
    rdata:  rdata_q,
    rid:    rid_q
  };

endmodule

`default_nettype wire

//--- verilog/user_irq_ctrl.sv
// Interrupt controller for the timers: sticky pending bits and a mask.
// Pending is cleared by writing 1, irq_o is pending AND mask.
`timescale 1ns/1ns
`default_nettype none

module user_irq_ctrl #(
  parameter int unsigned NumTimers = 4
) (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  user_pkg::obi_req_t   req_i,
  output user_pkg::obi_rsp_t   rsp_o,
  input  logic [NumTimers-1:0] events_i,
  output logic [NumTimers-1:0] irq_o
);
  import user_pkg::*;

  irq_reg_e             reg_sel;
  logic                 wr_en;
  logic [31:0]          wmask;
  logic [NumTimers-1:0] pending_q;
  logic [NumTimers-1:0] pending_clr;
  logic [NumTimers-1:0] mask_q;
  logic [31:0]          mask_new;
  logic [31:0]          rdata_d;

  logic                 rvalid_q;
  logic [3:0]           rid_q;
  logic [31:0]          rdata_q;

  // ------------------------------
  // Register writes
  // ------------------------------

  assign reg_sel  = irq_reg_e'(req_i.addr[3:2]);
  assign wr_en    = req_i.req & req_i.we;
  assign wmask    = be_to_mask(req_i.be);
  assign mask_new = merge_be(32'(mask_q), req_i.wdata, req_i.be);

  // Write-1-to-clear on enabled bytes only
  assign pending_clr = (wr_en && reg_sel == IrqPending) ?
                       (req_i.wdata[NumTimers-1:0] & wmask[NumTimers-1:0]) : '0;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      pending_q <= '0;
      mask_q    <= '0;
      rvalid_q  <= 1'b0;
    end else begin
      // New events win over a clear
      pending_q <= (pending_q & ~pending_clr) | events_i;
      rvalid_q  <= req_i.req;
      if (wr_en && reg_sel == IrqMask) begin
        mask_q <= mask_new[NumTimers-1:0];
      end
    end
  end

  assign irq_o = pending_q & mask_q;

  // ------------------------------
  // Read path
  // ------------------------------

  always_comb begin
    case (reg_sel)
      IrqPending: rdata_d = 32'(pending_q);
      IrqMask:    rdata_d = 32'(mask_q);
      default:    rdata_d = 32'd0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (req_i.req) begin
      rid_q   <= req_i.aid;
      rdata_q <= rdata_d;
    end
  end

  assign rsp_o = '{
    gnt:    req_i.req,
    rvalid: rvalid_q,
    err:    1'b0,
    rdata:  rdata_q,
    rid:    rid_q
  };

endmodule

`default_nettype wire

//--- verilog/user_domain.sv
// User domain top: OBI demux, error subordinate, irq controller and timers.
// The core connects through user_req_i / user_rsp_o.
`timescale 1ns/1ns
`default_nettype none

module user_domain #(
  parameter int unsigned NumTimers = 4
) (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  user_pkg::obi_req_t   user_req_i,
  output user_pkg::obi_rsp_t   user_rsp_o,
  output logic [NumTimers-1:0] interrupts_o
);
  import user_pkg::*;

  // One bus per target, ordered as target_e
  obi_req_t [NumTimers+1:0] tgt_req;
  obi_rsp_t [NumTimers+1:0] tgt_rsp;

  // Compare events, one per timer
  logic [NumTimers-1:0]     timer_events;

  // ------------------------------
  // Demux
  // ------------------------------

  user_obi_demux #(
    .NumTimers ( NumTimers )
  ) i_demux (
    .clk_i     ( clk_i      ),
    .rst_n_i   ( rst_n_i    ),
    .sbr_req_i ( user_req_i ),
    .sbr_rsp_o ( user_rsp_o ),
    .mgr_req_o ( tgt_req    ),
    .mgr_rsp_i ( tgt_rsp    )
  );

  // ------------------------------
  // Subordinates
  // ------------------------------

  // Unmapped regions
  user_err_sbr i_err_sbr (
    .clk_i   ( clk_i              ),
    .rst_n_i ( rst_n_i            ),
    .req_i   ( tgt_req[TargetErr] ),
    .rsp_o   ( tgt_rsp[TargetErr] )
  );

  user_irq_ctrl #(
    .NumTimers ( NumTimers )
  ) i_irq_ctrl (
    .clk_i    ( clk_i              ),
    .rst_n_i  ( rst_n_i            ),
    .req_i    ( tgt_req[TargetIrq] ),
    .rsp_o    ( tgt_rsp[TargetIrq] ),
    .events_i ( timer_events       ),
    .irq_o    ( interrupts_o       )
  );

  // Timer t sits on demux port TargetTimer + t
  for (genvar t = 0; t < NumTimers; t++) begin : gen_timer
    user_timer i_timer (
      .clk_i   ( clk_i                             ),
      .rst_n_i ( rst_n_i                           ),
      .req_i   ( tgt_req[int'(TargetTimer) + t]    ),
      .rsp_o   ( tgt_rsp[int'(TargetTimer) + t]    ),
      .event_o ( timer_events[t]                   )
    );
  end

endmodule

`default_nettype wire

//--- tests/tb_user_domain.sv
// Drives OBI accesses into the user domain and checks every response
// against a queue of expected values built from a small register model.
`timescale 1ns/1ns
`default_nettype none

module tb_user_domain;
  import user_pkg::*;

  localparam int unsigned NumTimers = 4;
  localparam int unsigned ClkPeriod = 100;
  localparam int unsigned DriveDly  = 10;
  // Largest compare value of the counting and irq tests
  localparam int unsigned MaxCmp    = 18;
  // Twice the reset, about 80 accesses of 3 cycles and six timer waits
  localparam int unsigned MaxCycles = 2 * (10 + 80 * 3 + 6 * (MaxCmp + 4));

  // One expected response with a compare mask for rdata
  typedef struct packed {
    logic [3:0]  aid;
    logic        err;
    logic [31:0] rdata;
    logic [31:0] mask;
  } exp_rsp_t;

  logic                 clk;
  logic                 rst_n;
  obi_req_t             user_req;
  obi_rsp_t             user_rsp;
  logic [NumTimers-1:0] irq;

  exp_rsp_t             exp_q[$];
  logic [31:0]          lfsr_state = 32'hd9d3_6e81;
  logic [31:0]          last_rdata;
  logic [3:0]           next_aid;
  int unsigned          cycle;
  int unsigned          gnt_cycle;
  int unsigned          errors;
  int unsigned          checks;
  string                test_name;
  // Register model
  logic [31:0]          model_cmp [NumTimers];
  logic [NumTimers-1:0] model_mask;

  user_domain #(
    .NumTimers ( NumTimers )
  ) i_dut (
    .clk_i        ( clk      ),
    .rst_n_i      ( rst_n    ),
    .user_req_i   ( user_req ),
    .user_rsp_o   ( user_rsp ),
    .interrupts_o ( irq      )
  );

  initial begin
    clk = 1'b0;
    forever #(ClkPeriod / 2) clk = ~clk;
  end

  // Cycle count and run limit
  initial begin
    cycle = 0;
    while (cycle < MaxCycles) begin
      @(posedge clk);
      cycle++;
    end
    $display("Timeout: run did not finish within %0d cycles", MaxCycles);
    $display("Errors found");
    $finish;
  end

  // ------------------------------
  // Helpers
  // ------------------------------

  function automatic void value_error(string what, logic [31:0] exp, logic [31:0] act);
    errors++;
    $display("ERROR %s %s: expected %h, actual %h", test_name, what, exp, act);
  endfunction

  function automatic void report_fail(string msg);
    errors++;
    $display("%s: %s", test_name, msg);
  endfunction

  task automatic check_value(input string what, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    assert (exp === act) else value_error(what, exp, act);
  endtask

  // Galois LFSR stepped once per bit taken
  function automatic logic [31:0] lfsr_take(input int unsigned nbits);
    logic [31:0] bits;
    bits = '0;
    for (int unsigned i = 0; i < nbits; i++) begin
      bits = {bits[30:0], lfsr_state[0]};
      lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'h8020_0003) : (lfsr_state >> 1);
    end
    return bits;
  endfunction

  function automatic logic [31:0] reg_addr(input int unsigned region, input logic [1:0] offset);
    return (32'(region) << RegionLsb) | {28'd0, offset, 2'b00};
  endfunction

  // Drive one request and hold it until granted
  // Returns at the next rising edge plus the drive delay
  task automatic issue(input logic we, input logic [31:0] addr, input logic [31:0] wdata,
                       input logic [31:0] exp_rdata, input logic [31:0] exp_mask,
                       input logic exp_err);
    exp_rsp_t entry;
    entry.aid   = next_aid;
    entry.err   = exp_err;
    entry.rdata = exp_rdata;
    entry.mask  = exp_mask;
    exp_q.push_back(entry);
    user_req.req   = 1'b1;
    user_req.we    = we;
    user_req.be    = 4'hF;
    user_req.addr  = addr;
    user_req.wdata = wdata;
    user_req.aid   = next_aid;
    next_aid       = next_aid + 4'd1;
    @(negedge clk);
    while (!user_rsp.gnt) @(negedge clk);
    gnt_cycle = cycle;
    @(posedge clk);
    #DriveDly;
  endtask

  // Drop req and wait for every outstanding response
  task automatic idle();
    user_req.req = 1'b0;
    while (exp_q.size() != 0) begin
      @(posedge clk);
      #DriveDly;
    end
  endtask

  task automatic write_reg(input logic [31:0] addr, input logic [31:0] data);
    issue(1'b1, addr, data, 32'd0, 32'd0, 1'b0);
    idle();
  endtask

  task automatic read_reg(input logic [31:0] addr, input logic [31:0] exp, input logic [31:0] mask);
    issue(1'b0, addr, 32'd0, exp, mask, 1'b0);
    idle();
  endtask

  // ------------------------------
  // Response checks
  // ------------------------------

  gnt_same_cycle: assert property (@(posedge clk) disable iff (!rst_n)
    user_req.req |-> user_rsp.gnt)
    else report_fail("request not granted in its own cycle");
  rvalid_after_gnt: assert property (@(posedge clk) disable iff (!rst_n)
    user_rsp.gnt |=> user_rsp.rvalid)
    else report_fail("no rvalid in the cycle after a grant");
  rvalid_needs_gnt: assert property (@(posedge clk) disable iff (!rst_n)
    user_rsp.rvalid |-> $past(user_rsp.gnt))
    else report_fail("rvalid without a grant in the previous cycle");

  // Mid-cycle compare against the head of the queue
  always @(negedge clk) begin
    exp_rsp_t head;
    if (rst_n && user_rsp.rvalid) begin
      if (exp_q.size() == 0) begin
        report_fail("rvalid with no request outstanding");
      end else begin
        head       = exp_q.pop_front();
        last_rdata = user_rsp.rdata;
        checks += 3;
        assert (user_rsp.rid == head.aid)
          else value_error("rid", 32'(head.aid), 32'(user_rsp.rid));
        assert (user_rsp.err == head.err)
          else value_error("err", 32'(head.err), 32'(user_rsp.err));
        assert ((user_rsp.rdata & head.mask) == (head.rdata & head.mask))
          else value_error("rdata", head.rdata & head.mask, user_rsp.rdata & head.mask);
      end
    end
  end

  // ------------------------------
  // Stimulus
  // ------------------------------

  initial begin
    int unsigned region;
    int unsigned cmp_c;
    int unsigned cmp_1;
    int unsigned en_cycle;
    int unsigned en_1;
    int unsigned end_cycle;
    int unsigned irq_cycle;
    logic        seen;
    rst_n     = 1'b0;
    user_req  = '0;
    next_aid  = 4'd0;
    errors    = 0;
    checks    = 0;
    test_name = "reset";
    for (int t = 0; t < NumTimers; t++) begin
      model_cmp[t] = 32'd0;
    end
    model_mask = '0;
    repeat (10) @(posedge clk);
    #DriveDly;
    rst_n = 1'b1;

    // Back-to-back reads of reset values and of an unmapped region
    test_name = "handshake";
    issue(1'b0, reg_addr(RegionIrq, IrqMask), 32'd0, 32'd0, 32'hFFFF_FFFF, 1'b0);
    issue(1'b0, reg_addr(RegionIrq, IrqPending), 32'd0, 32'd0, 32'hFFFF_FFFF, 1'b0);
    for (int unsigned t = 0; t < NumTimers; t++) begin
      issue(1'b0, reg_addr(t + 1, TimerCtrl), 32'd0, 32'd0, 32'hFFFF_FFFF, 1'b0);
    end
    issue(1'b0, reg_addr(9, TimerCtrl), 32'd0, ErrRspData, 32'hFFFF_FFFF, 1'b1);
    idle();

    // Each compare write is followed by a read of all timers
    test_name = "register access";
    for (int unsigned t = 0; t < NumTimers; t++) begin
      model_cmp[t] = lfsr_take(32);
      write_reg(reg_addr(t + 1, TimerCompare), model_cmp[t]);
      for (int unsigned u = 0; u < NumTimers; u++) begin
        read_reg(reg_addr(u + 1, TimerCompare), model_cmp[u], 32'hFFFF_FFFF);
      end
    end
    model_mask = NumTimers'(lfsr_take(NumTimers));
    write_reg(reg_addr(RegionIrq, IrqMask), 32'(model_mask));
    read_reg(reg_addr(RegionIrq, IrqMask), 32'(model_mask), 32'hFFFF_FFFF);

    test_name = "error path";
    for (int i = 0; i < 3; i++) begin
      region = 5 + lfsr_take(4) % 11;
      issue(1'b1, reg_addr(region, TimerCompare), lfsr_take(32), ErrRspData,
            32'hFFFF_FFFF, 1'b1);
      issue(1'b0, reg_addr(region, IrqMask), 32'd0, ErrRspData, 32'hFFFF_FFFF, 1'b1);
      idle();
    end
    // Nothing mapped may have moved
    for (int unsigned u = 0; u < NumTimers; u++) begin
      read_reg(reg_addr(u + 1, TimerCompare), model_cmp[u], 32'hFFFF_FFFF);
    end
    read_reg(reg_addr(RegionIrq, IrqMask), 32'(model_mask), 32'hFFFF_FFFF);

    // Count during cycle en+k is (k-1) mod (C+1)
    test_name = "timer counting";
    cmp_c = 3 + lfsr_take(4);
    write_reg(reg_addr(1, TimerCompare), 32'(cmp_c));
    write_reg(reg_addr(1, TimerCount), 32'd0);
    write_reg(reg_addr(1, TimerCtrl), 32'd1);
    en_cycle = gnt_cycle;
    for (int i = 0; i < 2; i++) begin
      repeat (lfsr_take(4)) begin
        @(posedge clk);
        #DriveDly;
      end
      issue(1'b0, reg_addr(1, TimerCount), 32'd0, 32'd0, 32'd0, 1'b0);
      idle();
      checks++;
      assert (last_rdata <= 32'(cmp_c)) else report_fail("count above the compare value");
      check_value("count", 32'((gnt_cycle - en_cycle - 1) % (cmp_c + 1)), last_rdata);
    end

    test_name = "interrupts";
    write_reg(reg_addr(1, TimerCtrl), 32'd0);
    write_reg(reg_addr(RegionIrq, IrqMask), 32'h1);
    write_reg(reg_addr(RegionIrq, IrqPending), 32'hF);
    check_value("interrupts after clear", 32'd0, 32'(irq));
    // Timer 1 runs masked out while timer 0 is masked in
    cmp_1 = 3 + lfsr_take(4);
    write_reg(reg_addr(2, TimerCompare), 32'(cmp_1));
    write_reg(reg_addr(2, TimerCount), 32'd0);
    write_reg(reg_addr(2, TimerCtrl), 32'd1);
    en_1 = gnt_cycle;
    cmp_c = 3 + lfsr_take(4);
    write_reg(reg_addr(1, TimerCompare), 32'(cmp_c));
    write_reg(reg_addr(1, TimerCount), 32'd0);
    write_reg(reg_addr(1, TimerCtrl), 32'd1);
    en_cycle  = gnt_cycle;
    end_cycle = (en_cycle + cmp_c > en_1 + cmp_1) ? en_cycle + cmp_c + 3 : en_1 + cmp_1 + 3;
    seen      = 1'b0;
    irq_cycle = 0;
    while (cycle <= end_cycle) begin
      @(negedge clk);
      if (irq[0] && !seen) begin
        seen      = 1'b1;
        irq_cycle = cycle;
      end
      checks++;
      assert (!irq[1]) else report_fail("masked-out timer raised its interrupt");
    end
    checks++;
    assert (seen && irq_cycle <= en_cycle + cmp_c + 3)
      else report_fail("timer 0 interrupt not raised in time");
    @(posedge clk);
    #DriveDly;
    write_reg(reg_addr(1, TimerCtrl), 32'd0);
    write_reg(reg_addr(RegionIrq, IrqPending), 32'h1);
    check_value("interrupts after write-1", 32'd0, 32'(irq));
    // Masked-out pending bit is still set
    read_reg(reg_addr(RegionIrq, IrqPending), 32'h2, 32'h2);

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- flist.f
verilog/user_pkg.sv
verilog/user_obi_demux.sv
verilog/user_err_sbr.sv
verilog/user_timer.sv
verilog/user_irq_ctrl.sv
verilog/user_domain.sv
tests/tb_user_domain.sv

//--- Makefile
# Verilator lint and simulation of the user domain testbench
VERILATOR := verilator
FLAGS     := --timing --assert
TOP       := tb_user_domain
FLIST     := flist.f
OBJ_DIR   := obj_dir
PASS_MSG  := No errors

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FLIST)

# Fails unless the pass message shows up as a line of its own
sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)
	out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
